// File: verilog.f
+incdir+logic
+incdir+dv
logic/ebr_ram_pkg.sv
logic/ebr_tile.sv
logic/ebr_port_decode.sv
logic/ebr_read_mux.sv
logic/ebr_ram_top.sv
dv/ebr_ram_tb.sv

// File: dv/ebr_ram_model.svh
// Reference model of the tiled RAM, included inside the testbench module to predict read data
`ifndef EBR_RAM_MODEL_SVH
`define EBR_RAM_MODEL_SVH

// Outcome of one sampled cycle
// one read flag and one read word per port
typedef struct packed {
  logic [`EBR_NUM_PORTS-1:0]               rd;
  ebr_ram_pkg::data_t [`EBR_NUM_PORTS-1:0] word;
} exp_entry_t;

// Memory image as the ports should see it
ebr_ram_pkg::data_t model_mem [`EBR_NUM_WORDS];

// Word each output register should hold right now
ebr_ram_pkg::data_t exp_rdata [`EBR_NUM_PORTS] = '{default: '0};

// Sampled cycles on their way to the output registers
exp_entry_t exp_q [$];

// Apply the requests sampled at one edge
// Reads see the image before any write of the same edge
function automatic void apply_sampled_reqs(
  input ebr_ram_pkg::port_req_t [`EBR_NUM_PORTS-1:0] reqs
);
  exp_entry_t e;
  e = '0;
  for (int p = 0; p < `EBR_NUM_PORTS; p++) begin
    if (reqs[p].req && !reqs[p].we) begin
      e.rd[p]   = 1'b1;
      e.word[p] = model_mem[reqs[p].addr];
    end
  end
  // Byte lanes merge into the stored word
  for (int p = 0; p < `EBR_NUM_PORTS; p++) begin
    if (reqs[p].req && reqs[p].we) begin
      for (int b = 0; b < `EBR_DATA_WIDTH / `EBR_BYTE_WIDTH; b++) begin
        if (reqs[p].be[b]) begin
          model_mem[reqs[p].addr][b*`EBR_BYTE_WIDTH +: `EBR_BYTE_WIDTH] =
            reqs[p].wdata[b*`EBR_BYTE_WIDTH +: `EBR_BYTE_WIDTH];
        end
      end
    end
  end
  exp_q.push_back(e);
endfunction

// Oldest sampled cycle reaches the output registers
// Ports without a read keep their word
function automatic void retire_expected();
  exp_entry_t e;
  if (exp_q.size() != 0) begin
    e = exp_q.pop_front();
    for (int p = 0; p < `EBR_NUM_PORTS; p++) begin
      if (e.rd[p]) begin
        exp_rdata[p] = e.word[p];
      end
    end
  end
endfunction

`endif

// File: dv/ebr_ram_tb.sv
// Self-checking testbench of the tiled dual-port RAM, simulate with ebr_ram_tb as top module
`timescale 1ns/1ps
`include "ebr_ram_config.svh"

module ebr_ram_tb;

  localparam int reset_cycles  = 10;
  localparam int random_cycles = 2000;
  // Reset, memory fill, directed phases and random traffic take about 2600 cycles
  localparam int timeout_cycles = 3000;

  logic                   clk;
  logic                   rst_n;
  ebr_ram_pkg::port_req_t req   [`EBR_NUM_PORTS];
  ebr_ram_pkg::data_t     rdata [`EBR_NUM_PORTS];

  integer seed;
  int     err_cnt   = 0;
  int     cycle_cnt = 0;

  `include "ebr_ram_model.svh"

  ebr_ram_top i_dut (
    .clk_i   (clk),
    .rst_ni  (rst_n),
    .req_i   (req),
    .rdata_o (rdata)
  );

  // 10 ns clock
  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Watchdog on the cycle count
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Compare one port's read word with the model
  task automatic check_rdata(input int port, input ebr_ram_pkg::data_t got,
                             input ebr_ram_pkg::data_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR @%0t: port %0d rdata %08h, expected %08h", $time, port, got, exp);
    end
  endtask

  function automatic ebr_ram_pkg::port_req_t write_req(input ebr_ram_pkg::addr_t addr,
                                                       input ebr_ram_pkg::data_t wdata,
                                                       input ebr_ram_pkg::be_t be);
    ebr_ram_pkg::port_req_t r;
    r.req   = 1'b1;
    r.we    = 1'b1;
    r.addr  = addr;
    r.wdata = wdata;
    r.be    = be;
    return r;
  endfunction

  function automatic ebr_ram_pkg::port_req_t read_req(input ebr_ram_pkg::addr_t addr);
    ebr_ram_pkg::port_req_t r;
    r       = '0;
    r.req   = 1'b1;
    r.addr  = addr;
    return r;
  endfunction

  // Background word, every address bit shows up twice
  function automatic ebr_ram_pkg::data_t fill_word(input ebr_ram_pkg::addr_t addr);
    return {6'h2b, addr, 6'h15, ~addr};
  endfunction

  // One clock cycle
  // check the outputs, log what the DUT just sampled, then drive the next requests
  task automatic run_cycle(input ebr_ram_pkg::port_req_t r0, input ebr_ram_pkg::port_req_t r1);
    @(posedge clk);
    #1;
    // Cycle sampled one edge earlier has just landed in the output registers
    retire_expected();
    for (int p = 0; p < `EBR_NUM_PORTS; p++) begin
      check_rdata(p, rdata[p], exp_rdata[p]);
    end
    apply_sampled_reqs({req[1], req[0]});
    req[0] = r0;
    req[1] = r1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) run_cycle('0, '0);
  endtask

  // Known contents everywhere, both ports write in parallel
  task automatic fill_memory();
    for (int i = 0; i < `EBR_NUM_WORDS; i += 2) begin
      run_cycle(write_req(ebr_ram_pkg::addr_t'(i), fill_word(ebr_ram_pkg::addr_t'(i)), '1),
                write_req(ebr_ram_pkg::addr_t'(i + 1), fill_word(ebr_ram_pkg::addr_t'(i + 1)), '1));
    end
  endtask

  // Full write on one port, read back on both
  task automatic cross_port_rw();
    ebr_ram_pkg::addr_t a;
    ebr_ram_pkg::data_t d;
    for (int k = 0; k < 8; k++) begin
      a = ebr_ram_pkg::addr_t'($random(seed));
      d = $random(seed);
      if (k % 2 == 0) begin
        run_cycle(write_req(a, d, '1), '0);
      end else begin
        run_cycle('0, write_req(a, d, '1));
      end
      run_cycle(read_req(a), read_req(a));
    end
  endtask

  // Every partial lane pattern over a known word
  task automatic partial_byte_writes();
    ebr_ram_pkg::addr_t a;
    ebr_ram_pkg::data_t base;
    ebr_ram_pkg::data_t upd;
    for (int b = 1; b < 15; b++) begin
      a    = ebr_ram_pkg::addr_t'($random(seed));
      base = $random(seed);
      upd  = $random(seed);
      run_cycle(write_req(a, base, '1), '0);
      run_cycle('0, write_req(a, upd, ebr_ram_pkg::be_t'(b)));
      run_cycle(read_req(a), '0);
    end
  endtask

  // Neighbours across each row cut must not alias
  task automatic row_boundaries();
    ebr_ram_pkg::addr_t edges [8] = '{0, 255, 256, 511, 512, 767, 768, 1023};
    for (int i = 0; i < 8; i += 2) begin
      run_cycle(write_req(edges[i], $random(seed), '1),
                write_req(edges[i + 1], $random(seed), '1));
    end
    for (int i = 0; i < 8; i += 2) begin
      run_cycle(read_req(edges[i]), read_req(edges[i + 1]));
    end
    // Same pairs again with the ports swapped
    for (int i = 0; i < 8; i += 2) begin
      run_cycle(read_req(edges[i + 1]), read_req(edges[i]));
    end
  endtask

  // Read and write of one word in the same cycle
  // old word first, new word on the next read
  task automatic same_cycle_collision();
    ebr_ram_pkg::addr_t a;
    ebr_ram_pkg::data_t d;
    for (int k = 0; k < 4; k++) begin
      a = ebr_ram_pkg::addr_t'($random(seed));
      d = $random(seed);
      if (k % 2 == 0) begin
        run_cycle(write_req(a, d, '1), read_req(a));
        run_cycle('0, read_req(a));
      end else begin
        run_cycle(read_req(a), write_req(a, d, '1));
        run_cycle(read_req(a), '0);
      end
    end
  endtask

  // Mixed idle, read and write traffic on both ports
  task automatic random_traffic();
    ebr_ram_pkg::port_req_t r [`EBR_NUM_PORTS];
    logic [31:0]            ctl;
    for (int n = 0; n < random_cycles; n++) begin
      for (int p = 0; p < `EBR_NUM_PORTS; p++) begin
        ctl  = $random(seed);
        r[p] = '0;
        // Roughly a quarter of the slots stay idle
        if (ctl[1:0] != 2'b00) begin
          r[p].req   = 1'b1;
          r[p].we    = ctl[2];
          r[p].addr  = ctl[12:3];
          r[p].be    = ctl[16:13];
          r[p].wdata = $random(seed);
        end
      end
      // Now and then both ports hit one word
      if (ctl[20:18] == 3'b000) begin
        r[1].addr = r[0].addr;
      end
      // Two writes to one word are undefined, so the second becomes a read
      if (r[0].req && r[0].we && r[1].req && r[1].we && r[0].addr == r[1].addr) begin
        r[1].we = 1'b0;
      end
      run_cycle(r[0], r[1]);
    end
  endtask

  initial begin
    seed  = 30;
    rst_n = 1'b0;
    req   = '{default: '0};
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Output registers leave reset cleared
    for (int p = 0; p < `EBR_NUM_PORTS; p++) begin
      check_rdata(p, rdata[p], '0);
    end
    fill_memory();
    cross_port_rw();
    partial_byte_writes();
    row_boundaries();
    same_cycle_collision();
    random_traffic();
    // Let the last reads reach the outputs
    idle_cycles(4);
    $display("Summary: %0d mismatches after %0d cycles", err_cnt, cycle_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: logic/ebr_ram_top.sv
// Top of the tiled true dual-port RAM that builds the tile grid around two port decoders
`timescale 1ns/1ps
`include "ebr_ram_config.svh"

module ebr_ram_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  ebr_ram_pkg::port_req_t req_i   [`EBR_NUM_PORTS],
  output ebr_ram_pkg::data_t     rdata_o [`EBR_NUM_PORTS]
);

  // Byte enables covered by one column
  localparam int unsigned slice_be = $bits(ebr_ram_pkg::slice_be_t);

  // Decoder outputs per port
  ebr_ram_pkg::row_sel_t   row_en    [`EBR_NUM_PORTS];
  ebr_ram_pkg::tile_addr_t tile_addr [`EBR_NUM_PORTS];
  ebr_ram_pkg::row_sel_t   rd_row_q  [`EBR_NUM_PORTS];

  // Registered tile slices indexed by port, row and column
  ebr_ram_pkg::slice_t tile_rdata [`EBR_NUM_PORTS][`EBR_NUM_ROWS][`EBR_NUM_COLS];

  // Address decode and output register per port
  for (genvar p = 0; p < `EBR_NUM_PORTS; p++) begin : gen_port
    ebr_port_decode i_decode (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (req_i[p]),
      .row_en_o    (row_en[p]),
      .tile_addr_o (tile_addr[p]),
      .rd_row_q_o  (rd_row_q[p])
    );

    ebr_read_mux i_read_mux (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .rd_row_q_i   (rd_row_q[p]),
      .row_slices_i (tile_rdata[p]),
      .rdata_o      (rdata_o[p])
    );
  end

  // Tile grid
  // every tile of a row shares the row enable, each column takes its own slice
  for (genvar r = 0; r < `EBR_NUM_ROWS; r++) begin : gen_row
    for (genvar c = 0; c < `EBR_NUM_COLS; c++) begin : gen_col
      logic                   en    [`EBR_NUM_PORTS];
      logic                   we    [`EBR_NUM_PORTS];
      ebr_ram_pkg::slice_t    wdata [`EBR_NUM_PORTS];
      ebr_ram_pkg::slice_be_t be    [`EBR_NUM_PORTS];
      ebr_ram_pkg::slice_t    rdata [`EBR_NUM_PORTS];

      for (genvar p = 0; p < `EBR_NUM_PORTS; p++) begin : gen_tile_port
        assign en[p]    = row_en[p][r];
        assign we[p]    = req_i[p].we;
        assign wdata[p] = req_i[p].wdata[c*`EBR_SLICE_WIDTH +: `EBR_SLICE_WIDTH];
        assign be[p]    = req_i[p].be[c*slice_be +: slice_be];
        // Route the slice back per port
        assign tile_rdata[p][r][c] = rdata[p];
      end

      ebr_tile #(
        .word_t (ebr_ram_pkg::slice_t)
      ) i_tile (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .en_i    (en),
        .we_i    (we),
        .addr_i  (tile_addr),
        .wdata_i (wdata),
        .be_i    (be),
        .rdata_o (rdata)
      );
    end
  end

endmodule

// File: logic/ebr_read_mux.sv
// Per-port output stage, joins the answering row's slices and holds the last read word
`timescale 1ns/1ps
`include "ebr_ram_config.svh"

module ebr_read_mux (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  ebr_ram_pkg::row_sel_t rd_row_q_i,
  input  ebr_ram_pkg::slice_t   row_slices_i [`EBR_NUM_ROWS][`EBR_NUM_COLS],
  output ebr_ram_pkg::data_t    rdata_o
);

  ebr_ram_pkg::data_t sel_word;
  ebr_ram_pkg::data_t rdata_q;

  // AND-OR select over the rows
  // Columns are placed side by side, column 0 in the low bits
  always_comb begin
    sel_word = '0;
    for (int r = 0; r < `EBR_NUM_ROWS; r++) begin
      for (int c = 0; c < `EBR_NUM_COLS; c++) begin
        if (rd_row_q_i[r]) begin
          sel_word[c*`EBR_SLICE_WIDTH +: `EBR_SLICE_WIDTH] =
            sel_word[c*`EBR_SLICE_WIDTH +: `EBR_SLICE_WIDTH] | row_slices_i[r][c];
        end
      end
    end
  end

  // Load on a pending read only
  // writes and idle cycles keep the previous word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (|rd_row_q_i) begin
      rdata_q <= sel_word;
    end
  end

  assign rdata_o = rdata_q;

  // The decoder never flags more than one answering row
  a_row_onehot0 : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_row_q_i))
    else $error("Read row select %b is not one-hot", rd_row_q_i);

endmodule

// File: logic/ebr_port_decode.sv
// Per-port address decoder that selects the tile row and tracks which row answers a read
`timescale 1ns/1ps
`include "ebr_ram_config.svh"

module ebr_port_decode (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  ebr_ram_pkg::port_req_t  req_i,
  output ebr_ram_pkg::row_sel_t   row_en_o,
  output ebr_ram_pkg::tile_addr_t tile_addr_o,
  output ebr_ram_pkg::row_sel_t   rd_row_q_o
);

  // Upper address bits pick the row and lower bits address inside the tile
  localparam int unsigned row_bits   = $clog2(`EBR_NUM_ROWS);
  localparam int unsigned local_bits = $bits(ebr_ram_pkg::tile_addr_t);

  logic [row_bits-1:0]   row_idx;
  ebr_ram_pkg::row_sel_t row_onehot;
  ebr_ram_pkg::row_sel_t rd_row_q;
  logic                  rd_req;

  assign row_idx     = req_i.addr[local_bits +: row_bits];
  assign tile_addr_o = req_i.addr[local_bits-1:0];

  // Row index to one-hot
  always_comb begin
    row_onehot = '0;
    row_onehot[row_idx] = 1'b1;
  end

  // Only the addressed row sees the access
  assign row_en_o = req_i.req ? row_onehot : '0;

  // A read is a request without write strobe
  assign rd_req = req_i.req && !req_i.we;

  // Row of the read, lined up with the tile read register
  // Cleared when the cycle carried no read, so the output stage holds
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_row_q <= '0;
    end else begin
      rd_row_q <= rd_req ? row_onehot : '0;
    end
  end

  assign rd_row_q_o = rd_row_q;

  // A valid request carries a known write strobe and address
  property p_req_known;
    @(posedge clk_i) disable iff (!rst_ni)
      req_i.req |-> !$isunknown({req_i.we, req_i.addr});
  endproperty

  a_req_known : assert property (p_req_known)
    else $error("Request with unknown write strobe or address %0h", req_i.addr);

endmodule

// File: logic/ebr_tile.sv
// Behavioural dual-port block RAM tile with byte-lane writes and read-before-write output
`timescale 1ns/1ps
`include "ebr_ram_config.svh"

module ebr_tile #(
  parameter type word_t = ebr_ram_pkg::slice_t
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    en_i    [`EBR_NUM_PORTS],
  input  logic                    we_i    [`EBR_NUM_PORTS],
  input  ebr_ram_pkg::tile_addr_t addr_i  [`EBR_NUM_PORTS],
  input  word_t                   wdata_i [`EBR_NUM_PORTS],
  input  ebr_ram_pkg::slice_be_t  be_i    [`EBR_NUM_PORTS],
  output word_t                   rdata_o [`EBR_NUM_PORTS]
);

  // Byte lanes packed into one stored word
  localparam int unsigned num_lanes = $bits(word_t) / `EBR_BYTE_WIDTH;

  // Storage array
  word_t mem_q [`EBR_TILE_DEPTH];

  // Per-port read register
  word_t rdata_q [`EBR_NUM_PORTS];

  // Write side
  // Each port updates only the lanes it enables
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `EBR_NUM_PORTS; p++) begin
      if (en_i[p] && we_i[p]) begin
        for (int l = 0; l < num_lanes; l++) begin
          if (be_i[p][l]) begin
            mem_q[addr_i[p]][l*`EBR_BYTE_WIDTH +: `EBR_BYTE_WIDTH] <=
              wdata_i[p][l*`EBR_BYTE_WIDTH +: `EBR_BYTE_WIDTH];
          end
        end
      end
    end
  end

  // Read side
  // Nonblocking sample of the array gives the contents from before this edge's writes
  // Any enabled access loads the register, writes included
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '{default: '0};
    end else begin
      for (int p = 0; p < `EBR_NUM_PORTS; p++) begin
        if (en_i[p]) begin
          rdata_q[p] <= mem_q[addr_i[p]];
        end
      end
    end
  end

  assign rdata_o = rdata_q;

  // Two writes to one word in the same cycle leave the result undefined
  property p_no_dual_write;
    @(posedge clk_i) disable iff (!rst_ni)
      (en_i[0] && we_i[0] && en_i[1] && we_i[1]) |-> (addr_i[0] != addr_i[1]);
  endproperty

  a_no_dual_write : assert property (p_no_dual_write)
    else $error("Both ports write tile address %0h in one cycle", addr_i[0]);

endmodule

// File: logic/ebr_ram_pkg.sv
// Shared types of the tiled dual-port RAM, referenced by scoped name from every RTL file
`include "ebr_ram_config.svh"

package ebr_ram_pkg;

  // Word address over the whole memory
  typedef logic [$clog2(`EBR_NUM_WORDS)-1:0] addr_t;

  // Full data word as seen on a port
  typedef logic [`EBR_DATA_WIDTH-1:0] data_t;

  // One enable per byte lane of a word
  typedef logic [`EBR_DATA_WIDTH/`EBR_BYTE_WIDTH-1:0] be_t;

  // Column slice stored in a single tile
  typedef logic [`EBR_SLICE_WIDTH-1:0] slice_t;

  // Byte lanes covered by one slice
  typedef logic [`EBR_SLICE_WIDTH/`EBR_BYTE_WIDTH-1:0] slice_be_t;

  // Word address local to one tile
  typedef logic [$clog2(`EBR_TILE_DEPTH)-1:0] tile_addr_t;

  // One-hot select of a tile row
  typedef logic [`EBR_NUM_ROWS-1:0] row_sel_t;

  // Request of one port
  // req marks a valid access in this cycle, we turns it into a write
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    be_t   be;
  } port_req_t;

endpackage

// File: logic/ebr_ram_config.svh
// Geometry of the tiled dual-port RAM, included by the package, the RTL and the testbench
`ifndef EBR_RAM_CONFIG_SVH
`define EBR_RAM_CONFIG_SVH

// Number of independent access ports
`define EBR_NUM_PORTS 2

// Full data word and byte lane width
`define EBR_DATA_WIDTH 32
`define EBR_BYTE_WIDTH 8

// One column slice per tile, two byte lanes wide
`define EBR_SLICE_WIDTH 16

// Words held by one tile
`define EBR_TILE_DEPTH 256

// Tile grid, columns split the word and rows split the address space
`define EBR_NUM_COLS 2
`define EBR_NUM_ROWS 4

// Total depth, equal to rows times tile depth
`define EBR_NUM_WORDS 1024

`endif
